// File: common/mac_config.svh
// systolic MAC array configuration
// array edge, operand and word widths, memory depth

`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

// array edge, also the largest M, N or T
`define MAC_DIM        4

`define MAC_OPERAND_W  8
`define MAC_PSUM_W     16
`define MAC_WORD_W     64

// rows per I, W memory
`define MAC_MEM_DEPTH  8

`endif

// File: common/mac_data_pkg.sv
// data types of the MAC array datapath
// operands, partial sums, memory words and addresses

`include "mac_config.svh"

package mac_data_pkg;

    typedef logic [`MAC_OPERAND_W-1:0] operand_t;
    typedef logic [`MAC_PSUM_W-1:0]    psum_t;
    typedef logic [`MAC_WORD_W-1:0]    mem_word_t;

    // I and W rows
    typedef logic [$clog2(`MAC_MEM_DEPTH)-1:0]   in_addr_t;
    // O rows, one bit wider
    typedef logic [$clog2(2*`MAC_MEM_DEPTH)-1:0] out_addr_t;

endpackage

// File: common/mac_ctrl_pkg.sv
// control types of the MAC array
// sequencer states and the M, N, T field type

package mac_ctrl_pkg;

    typedef logic [3:0] dim_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_W,
        STREAM,
        FLUSH,
        WRITE_O
    } mac_state_t;

endpackage

// File: common/array_if.sv
// array interface
// links the sequencer, the PE grid and the result buffer

`timescale 1ns/100ps
`include "mac_config.svh"

interface array_if;
    import mac_data_pkg::*;

    logic                w_clear;
    logic                w_load;
    in_addr_t            w_row;
    logic                act_valid;
    logic [`MAC_DIM-1:0] sum_valid;
    psum_t [`MAC_DIM-1:0] sums;
    logic                rows_ready;

    modport ctrl (output w_clear, w_load, w_row, act_valid, input rows_ready);
    modport grid (input w_clear, w_load, w_row, act_valid, output sum_valid, sums);
    modport rbuf (input w_clear, sum_valid, sums, output rows_ready);

endinterface

// File: hw/mac_ctrl/step_counter.sv
// phase step counter
// counts from zero after a clear and holds on limit-1

`timescale 1ns/100ps

module step_counter (
    input  logic                   CLK,
    input  logic                   RSTN,
    input  logic                   step_clear,
    input  mac_ctrl_pkg::dim_t     step_limit,
    output mac_data_pkg::in_addr_t step,
    output logic                   step_last
);
    import mac_ctrl_pkg::*;

    assign step_last = (dim_t'(step) == step_limit - 1'b1);

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            step <= '0;
        end else if (step_clear) begin
            step <= '0;
        end else if (!step_last) begin
            step <= step + 1'b1;
        end
    end

endmodule

// File: hw/mac_ctrl/mac_fsm.sv
// MAC array sequencer
// checks and latches M, N, T on START, then walks the weight load,
// input stream, flush and write-back phases off the shared step count

`timescale 1ns/100ps
`include "mac_config.svh"

module mac_fsm (
    input  logic                    CLK,
    input  logic                    RSTN,
    input  logic [11:0]             MNT,
    input  logic                    START,
    array_if.ctrl                   ctrl,
    input  mac_data_pkg::in_addr_t  step,
    input  logic                    step_last,
    output logic                    step_clear,
    output mac_ctrl_pkg::dim_t      step_limit,
    output logic                    EN_I,
    output mac_data_pkg::in_addr_t  ADDR_I,
    output logic                    EN_W,
    output mac_data_pkg::in_addr_t  ADDR_W,
    output logic                    EN_O,
    output logic                    RW_O,
    output mac_data_pkg::out_addr_t ADDR_O,
    output mac_ctrl_pkg::dim_t      m_count
);
    import mac_data_pkg::*;
    import mac_ctrl_pkg::*;

    mac_state_t state_q;
    dim_t       mnt_m;
    dim_t       mnt_n;
    dim_t       mnt_t;
    dim_t       m_q;
    dim_t       n_q;
    dim_t       t_q;
    logic       start_ok;

    assign mnt_m = MNT[11:8];
    assign mnt_n = MNT[7:4];
    assign mnt_t = MNT[3:0];

    // every field in 1..MAC_DIM, accepted in IDLE only
    assign start_ok = START && (state_q == IDLE)
                      && (mnt_m != '0) && (mnt_m <= `MAC_DIM)
                      && (mnt_n != '0) && (mnt_n <= `MAC_DIM)
                      && (mnt_t != '0) && (mnt_t <= `MAC_DIM);

    assign ctrl.w_clear = start_ok;

    assign step_clear = (state_q == IDLE) || (state_q == FLUSH)
                        || ((state_q == LOAD_W) && step_last);
    assign step_limit = (state_q == LOAD_W) ? n_q : t_q;
    assign m_count    = m_q;

    assign EN_W   = (state_q == LOAD_W);
    assign ADDR_W = step;
    assign EN_I   = (state_q == STREAM);
    assign ADDR_I = step;
    assign EN_O   = (state_q == WRITE_O);
    assign RW_O   = (state_q == WRITE_O);
    assign ADDR_O = out_addr_t'(step);

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            state_q        <= IDLE;
            m_q            <= '0;
            n_q            <= '0;
            t_q            <= '0;
            ctrl.w_load    <= 1'b0;
            ctrl.act_valid <= 1'b0;
        end else begin
            // memory data lands one cycle after the enable
            ctrl.w_load    <= EN_W;
            ctrl.act_valid <= EN_I;
            case (state_q)
                IDLE: begin
                    if (start_ok) begin
                        m_q     <= mnt_m;
                        n_q     <= mnt_n;
                        t_q     <= mnt_t;
                        state_q <= LOAD_W;
                    end
                end
                LOAD_W:  if (step_last) state_q <= STREAM;
                STREAM:  if (step_last) state_q <= FLUSH;
                FLUSH:   if (ctrl.rows_ready) state_q <= WRITE_O;
                WRITE_O: if (step_last) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        ctrl.w_row <= step;
    end

endmodule

// File: hw/mac_array/pe_cell.sv
// processing element
// keeps one weight, passes the activation east and the
// accumulated partial sum south

`timescale 1ns/100ps

module pe_cell (
    input  logic                   CLK,
    input  logic                   RSTN,
    input  logic                   w_clear,
    input  logic                   w_load,
    input  mac_data_pkg::operand_t w_in,
    input  mac_data_pkg::operand_t act_in,
    input  mac_data_pkg::psum_t    psum_in,
    output mac_data_pkg::operand_t act_out,
    output mac_data_pkg::psum_t    psum_out
);
    import mac_data_pkg::*;

    operand_t weight_q;
    psum_t    product;

    // widened to the partial-sum width before the multiply
    assign product = act_in * weight_q;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            weight_q <= '0;
        end else if (w_clear) begin
            weight_q <= '0;
        end else if (w_load) begin
            weight_q <= w_in;
        end
    end

    always_ff @(posedge CLK) begin
        act_out  <= act_in;
        psum_out <= psum_in + product;
    end

endmodule

// File: hw/mac_array/pe_grid.sv
// 4x4 weight-stationary PE grid
// weight rows load by index, input bytes enter skewed by row,
// column sums leave at the bottom with their valid tags

`timescale 1ns/100ps
`include "mac_config.svh"

module pe_grid (
    input  logic                    CLK,
    input  logic                    RSTN,
    array_if.grid                   grid,
    input  mac_data_pkg::mem_word_t rdata_w,
    input  mac_data_pkg::mem_word_t rdata_i
);
    import mac_data_pkg::*;

    localparam int TAG_D = 2 * `MAC_DIM - 1;

    operand_t            act_h  [`MAC_DIM][`MAC_DIM+1];
    psum_t               psum_v [`MAC_DIM+1][`MAC_DIM];
    logic [`MAC_DIM-1:0] row_load;
    logic [TAG_D-1:0]    tag_q;

    ////////////////////////////////////////
    // valid tag pipeline
    ////////////////////////////////////////
    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            tag_q <= '0;
        end else begin
            tag_q <= {tag_q[TAG_D-2:0], grid.act_valid};
        end
    end

    ////////////////////////////////////////
    // input skew and PE array
    ////////////////////////////////////////
    for (genvar r = 0; r < `MAC_DIM; r++) begin : g_row
        operand_t act_byte;

        assign row_load[r] = grid.w_load && (grid.w_row == r);
        // byte r of the input row, quiet outside valid cycles
        assign act_byte = grid.act_valid
                          ? rdata_i[`MAC_WORD_W-1-r*`MAC_OPERAND_W -: `MAC_OPERAND_W]
                          : '0;

        if (r == 0) begin : g_pass
            assign act_h[r][0] = act_byte;
        end else begin : g_skew
            operand_t skew_q [r];

            always_ff @(posedge CLK) begin
                skew_q[0] <= act_byte;
                for (int k = 1; k < r; k++) begin
                    skew_q[k] <= skew_q[k-1];
                end
            end
            assign act_h[r][0] = skew_q[r-1];
        end

        for (genvar c = 0; c < `MAC_DIM; c++) begin : g_col
            pe_cell u_pe (
                .CLK      (CLK),
                .RSTN     (RSTN),
                .w_clear  (grid.w_clear),
                .w_load   (row_load[r]),
                .w_in     (rdata_w[`MAC_WORD_W-1-c*`MAC_OPERAND_W -: `MAC_OPERAND_W]),
                .act_in   (act_h[r][c]),
                .psum_in  (psum_v[r][c]),
                .act_out  (act_h[r][c+1]),
                .psum_out (psum_v[r+1][c])
            );
        end
    end

    // column c finishes MAC_DIM + c cycles after its input row
    for (genvar c = 0; c < `MAC_DIM; c++) begin : g_edge
        assign psum_v[0][c]       = '0;
        assign grid.sums[c]       = psum_v[`MAC_DIM][c];
        assign grid.sum_valid[c]  = tag_q[`MAC_DIM-1+c];
    end

endmodule

// File: hw/result_buffer.sv
// result buffer
// lines up the column sums, keeps the finished rows in order and
// builds the O word for the row being written

`timescale 1ns/100ps
`include "mac_config.svh"

module result_buffer (
    input  logic                    CLK,
    input  logic                    RSTN,
    array_if.rbuf                   rbuf,
    input  mac_ctrl_pkg::dim_t      m_count,
    input  mac_ctrl_pkg::dim_t      t_count,
    input  mac_data_pkg::out_addr_t rd_row,
    output mac_data_pkg::mem_word_t wdata
);
    import mac_data_pkg::*;
    import mac_ctrl_pkg::*;

    localparam int ROW_W = $clog2(`MAC_DIM);

    psum_t               col_sum [`MAC_DIM];
    logic [`MAC_DIM-1:0] col_vld;
    psum_t               rows_q  [`MAC_DIM][`MAC_DIM];
    dim_t                row_count;

    // column c waits MAC_DIM-1-c cycles
    for (genvar c = 0; c < `MAC_DIM; c++) begin : g_deskew
        localparam int DEPTH = `MAC_DIM - 1 - c;

        if (DEPTH == 0) begin : g_pass
            assign col_sum[c] = rbuf.sums[c];
            assign col_vld[c] = rbuf.sum_valid[c];
        end else begin : g_delay
            psum_t            sum_q [DEPTH];
            logic [DEPTH-1:0] vld_q;

            always_ff @(posedge CLK or negedge RSTN) begin
                if (!RSTN) begin
                    vld_q <= '0;
                end else begin
                    vld_q[0] <= rbuf.sum_valid[c];
                    for (int k = 1; k < DEPTH; k++) begin
                        vld_q[k] <= vld_q[k-1];
                    end
                end
            end

            always_ff @(posedge CLK) begin
                sum_q[0] <= rbuf.sums[c];
                for (int k = 1; k < DEPTH; k++) begin
                    sum_q[k] <= sum_q[k-1];
                end
            end

            assign col_sum[c] = sum_q[DEPTH-1];
            assign col_vld[c] = vld_q[DEPTH-1];
        end
    end

    ////////////////////////////////////////
    // row store
    ////////////////////////////////////////
    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            row_count <= '0;
        end else if (rbuf.w_clear) begin
            row_count <= '0;
        end else if (&col_vld) begin
            row_count <= row_count + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (&col_vld && (row_count < `MAC_DIM)) begin
            rows_q[row_count[ROW_W-1:0]] <= col_sum;
        end
    end

    assign rbuf.rows_ready = (row_count == t_count);

    // fields past M go out as zero
    always_comb begin
        wdata = '0;
        for (int m = 0; m < `MAC_DIM; m++) begin
            if (m < m_count) begin
                wdata[`MAC_WORD_W-1-m*`MAC_PSUM_W -: `MAC_PSUM_W] =
                    rows_q[rd_row[ROW_W-1:0]][m];
            end
        end
    end

endmodule

// File: hw/macarray.sv
// systolic MAC array top
// one O = I x W product per START, with I, W and O held in
// external synchronous memories

`timescale 1ns/100ps

module macarray (
    input  logic                    CLK,
    input  logic                    RSTN,
    input  logic [11:0]             MNT,
    input  logic                    START,

    output logic                    EN_I,
    output mac_data_pkg::in_addr_t  ADDR_I,
    input  mac_data_pkg::mem_word_t RDATA_I,
    output logic                    EN_W,
    output mac_data_pkg::in_addr_t  ADDR_W,
    input  mac_data_pkg::mem_word_t RDATA_W,

    output logic                    EN_O,
    output logic                    RW_O,
    output mac_data_pkg::out_addr_t ADDR_O,
    output mac_data_pkg::mem_word_t WDATA_O,
    input  mac_data_pkg::mem_word_t RDATA_O
);
    import mac_data_pkg::*;
    import mac_ctrl_pkg::*;

    in_addr_t step;
    logic     step_last;
    logic     step_clear;
    dim_t     step_limit;
    dim_t     m_count;

    array_if u_array_if ();

    mac_fsm u_mac_fsm (
        .CLK        (CLK),
        .RSTN       (RSTN),
        .MNT        (MNT),
        .START      (START),
        .ctrl       (u_array_if.ctrl),
        .step       (step),
        .step_last  (step_last),
        .step_clear (step_clear),
        .step_limit (step_limit),
        .EN_I       (EN_I),
        .ADDR_I     (ADDR_I),
        .EN_W       (EN_W),
        .ADDR_W     (ADDR_W),
        .EN_O       (EN_O),
        .RW_O       (RW_O),
        .ADDR_O     (ADDR_O),
        .m_count    (m_count)
    );

    step_counter u_step_counter (
        .CLK        (CLK),
        .RSTN       (RSTN),
        .step_clear (step_clear),
        .step_limit (step_limit),
        .step       (step),
        .step_last  (step_last)
    );

    pe_grid u_pe_grid (
        .CLK     (CLK),
        .RSTN    (RSTN),
        .grid    (u_array_if.grid),
        .rdata_w (RDATA_W),
        .rdata_i (RDATA_I)
    );

    // step limit is T outside the weight load
    result_buffer u_result_buffer (
        .CLK     (CLK),
        .RSTN    (RSTN),
        .rbuf    (u_array_if.rbuf),
        .m_count (m_count),
        .t_count (step_limit),
        .rd_row  (ADDR_O),
        .wdata   (WDATA_O)
    );

endmodule

// File: sim/sram_model.sv
// synchronous single-port memory model
// read data appears one cycle after the enable, writes when we is high

`timescale 1ns/100ps

module sram_model #(
    parameter int AW = 3,
    parameter int DW = 64
) (
    input  logic          CLK,
    input  logic          en,
    input  logic          we,
    input  logic [AW-1:0] addr,
    input  logic [DW-1:0] wdata,
    output logic [DW-1:0] rdata
);

    logic [DW-1:0] mem [2**AW];

    always @(posedge CLK) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: sim/tb_macarray.sv
// testbench for the systolic MAC array
// runs a table of M, N, T shapes and checks every O write
// against a behavioral matrix product

`timescale 1ns/100ps
`include "mac_config.svh"

module tb_macarray;

    localparam int NUM_CASES    = 13;
    localparam int RUN_TIMEOUT  = 200;
    localparam int QUIET_WINDOW = 40;

    logic        CLK;
    logic        RSTN;
    logic [11:0] MNT;
    logic        START;
    logic        EN_I;
    logic [2:0]  ADDR_I;
    logic [63:0] RDATA_I;
    logic        EN_W;
    logic [2:0]  ADDR_W;
    logic [63:0] RDATA_W;
    logic        EN_O;
    logic        RW_O;
    logic [3:0]  ADDR_O;
    logic [63:0] WDATA_O;
    logic [63:0] RDATA_O;

    // memory preload port shared by I and W
    logic        load_en;
    logic [2:0]  load_addr;
    logic [63:0] load_i;
    logic [63:0] load_w;

    logic [31:0] lcg_state;
    logic [63:0] i_rows [`MAC_MEM_DEPTH];
    logic [63:0] w_rows [`MAC_MEM_DEPTH];
    logic [12:0] case_table [NUM_CASES];
    int          error_count;
    int          check_count;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    always #2 CLK = ~CLK;

    macarray DUT (
        .CLK     (CLK),
        .RSTN    (RSTN),
        .MNT     (MNT),
        .START   (START),
        .EN_I    (EN_I),
        .ADDR_I  (ADDR_I),
        .RDATA_I (RDATA_I),
        .EN_W    (EN_W),
        .ADDR_W  (ADDR_W),
        .RDATA_W (RDATA_W),
        .EN_O    (EN_O),
        .RW_O    (RW_O),
        .ADDR_O  (ADDR_O),
        .WDATA_O (WDATA_O),
        .RDATA_O (RDATA_O)
    );

    sram_model #(.AW(3)) u_mem_i (
        .CLK   (CLK),
        .en    (EN_I || load_en),
        .we    (load_en),
        .addr  (load_en ? load_addr : ADDR_I),
        .wdata (load_i),
        .rdata (RDATA_I)
    );

    sram_model #(.AW(3)) u_mem_w (
        .CLK   (CLK),
        .en    (EN_W || load_en),
        .we    (load_en),
        .addr  (load_en ? load_addr : ADDR_W),
        .wdata (load_w),
        .rdata (RDATA_W)
    );

    sram_model #(.AW(4)) u_mem_o (
        .CLK   (CLK),
        .en    (EN_O),
        .we    (RW_O),
        .addr  (ADDR_O),
        .wdata (WDATA_O),
        .rdata (RDATA_O)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // O[t][m] is the sum over n < N of I[t][n] * W[n][m] modulo 2^16
    function automatic logic [63:0] expected_word(input int t, input logic [11:0] mnt);
        logic [63:0] word;
        logic [15:0] acc;
        word = '0;
        for (int m = 0; m < mnt[11:8]; m++) begin
            acc = '0;
            for (int n = 0; n < mnt[7:4]; n++) begin
                acc = acc + i_rows[t][63-8*n -: 8] * w_rows[n][63-8*m -: 8];
            end
            word[63-16*m -: 16] = acc;
        end
        return word;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error: %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic fill_memories();
        for (int a = 0; a < `MAC_MEM_DEPTH; a++) begin
            lcg_state = lcg_next(lcg_state);
            i_rows[a][63:32] = lcg_state;
            lcg_state = lcg_next(lcg_state);
            i_rows[a][31:0] = lcg_state;
            lcg_state = lcg_next(lcg_state);
            w_rows[a][63:32] = lcg_state;
            lcg_state = lcg_next(lcg_state);
            w_rows[a][31:0] = lcg_state;
            load_en   = 1'b1;
            load_addr = 3'(a);
            load_i    = i_rows[a];
            load_w    = w_rows[a];
            @(posedge CLK);
            #1;
        end
        load_en = 1'b0;
    endtask

    task automatic report_test(input string label, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: passed", label);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", label, error_count - errors_before);
        end
    endtask

    // pulse START and watch the memory ports until the run is over
    task automatic run_case(input logic [11:0] mnt, input logic restart);
        logic [63:0] cap_addr [16];
        logic [63:0] cap_data [16];
        logic [3:0]  n_dim;
        logic [3:0]  t_dim;
        logic        valid;
        int          limit;
        int          cycle;
        int          w_reads;
        int          i_reads;
        int          o_writes;
        int          quiet;
        n_dim = mnt[7:4];
        t_dim = mnt[3:0];
        valid = (mnt[11:8] >= 1) && (mnt[11:8] <= `MAC_DIM)
                && (n_dim >= 1) && (n_dim <= `MAC_DIM)
                && (t_dim >= 1) && (t_dim <= `MAC_DIM);
        limit    = valid ? RUN_TIMEOUT : QUIET_WINDOW;
        cycle    = 0;
        w_reads  = 0;
        i_reads  = 0;
        o_writes = 0;
        quiet    = 0;
        fill_memories();
        MNT   = mnt;
        START = 1'b1;
        while ((cycle < limit) && (quiet < 4)) begin
            @(negedge CLK);
            if (EN_W) begin
                check_value("ADDR_W", 64'(ADDR_W), 64'(w_reads));
                w_reads++;
            end
            if (EN_I) begin
                check_value("ADDR_I", 64'(ADDR_I), 64'(i_reads));
                i_reads++;
            end
            if (EN_O) begin
                check_value("RW_O", 64'(RW_O), 64'd1);
                if (o_writes < 16) begin
                    cap_addr[o_writes] = 64'(ADDR_O);
                    cap_data[o_writes] = WDATA_O;
                end
                o_writes++;
            end
            if (valid && (o_writes >= t_dim) && !EN_O) begin
                quiet++;
            end
            @(posedge CLK);
            #1;
            // a second START while busy with a different shape
            if (restart && (cycle == 2)) begin
                MNT   = 12'h111;
                START = 1'b1;
            end else begin
                START = 1'b0;
            end
            cycle++;
        end
        if (!valid) begin
            check_value("enable activity", 64'(w_reads + i_reads + o_writes), 64'd0);
        end else if (quiet < 4) begin
            error_count++;
            timed_out = 1'b1;
            $display("timeout: MNT %03h run gave %0d of %0d O writes", mnt, o_writes, t_dim);
        end else begin
            check_value("W read count", 64'(w_reads), 64'(n_dim));
            check_value("I read count", 64'(i_reads), 64'(t_dim));
            check_value("O write count", 64'(o_writes), 64'(t_dim));
            for (int t = 0; (t < t_dim) && (t < o_writes); t++) begin
                check_value("ADDR_O", cap_addr[t], 64'(t));
                check_value("WDATA_O", cap_data[t], expected_word(t, mnt));
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int errors_before;
        CLK          = 1'b0;
        RSTN         = 1'b0;
        START        = 1'b0;
        MNT          = '0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_i       = '0;
        load_w       = '0;
        lcg_state    = 32'h1ca7_8b4d;
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;

        // bit 12 asks for a START during the run
        case_table[0]  = {1'b0, 12'h444};
        case_table[1]  = {1'b0, 12'h111};
        case_table[2]  = {1'b0, 12'h234};
        case_table[3]  = {1'b0, 12'h413};
        case_table[4]  = {1'b0, 12'h044};
        case_table[5]  = {1'b0, 12'h454};
        case_table[6]  = {1'b1, 12'h342};
        case_table[7]  = {1'b0, 12'h544};
        case_table[8]  = {1'b0, 12'h404};
        case_table[9]  = {1'b0, 12'h440};
        case_table[10] = {1'b0, 12'h445};
        case_table[11] = {1'b0, 12'h324};
        case_table[12] = {1'b1, 12'h141};

        // enables stay low through reset and until the first START
        errors_before = error_count;
        for (int k = 0; k < 10; k++) begin
            @(negedge CLK);
            check_value("enables in reset", 64'({EN_I, EN_W, EN_O, RW_O}), 64'd0);
        end
        @(posedge CLK);
        #1;
        RSTN = 1'b1;
        for (int k = 0; k < 3; k++) begin
            @(negedge CLK);
            check_value("enables after reset", 64'({EN_I, EN_W, EN_O, RW_O}), 64'd0);
        end
        @(posedge CLK);
        #1;
        report_test("reset", errors_before);

        for (int i = 0; (i < NUM_CASES) && !timed_out; i++) begin
            errors_before = error_count;
            run_case(case_table[i][11:0], case_table[i][12]);
            report_test($sformatf("%0d mnt %03h", i, case_table[i][11:0]), errors_before);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/mac_data_pkg.sv
common/mac_ctrl_pkg.sv
common/array_if.sv
hw/mac_ctrl/step_counter.sv
hw/mac_ctrl/mac_fsm.sv
hw/mac_array/pe_cell.sv
hw/mac_array/pe_grid.sv
hw/result_buffer.sv
hw/macarray.sv
sim/sram_model.sv
sim/tb_macarray.sv

// File: Makefile
# Verilator build and run for the systolic MAC array

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= tb_macarray
LINT_TOP  ?= macarray
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
